// ==== harmonica_settings.svh ====
/*
  machine sizes for the warp pipeline
  instruction fields are fixed at 3-bit registers and a 15-bit immediate,
  so NUM_REGS must stay at 8 unless the instruction layout changes
*/
`ifndef HARMONICA_SETTINGS_SVH
`define HARMONICA_SETTINGS_SVH

// ========================================
// machine shape
// ========================================
`define NUM_WARPS 4    // warps resident in the table
`define NUM_LANES 4    // SIMD lanes per warp

// ========================================
// widths and register counts
// ========================================
`define WORD_WIDTH 32  // lane data width
`define NUM_REGS 8     // gpr and predicate registers per lane
`define PC_WIDTH 16    // word addressed, instruction and data

`endif

// ==== harmonica_pkg.sv ====
/*
  shared types of the warp pipeline
  instruction word is 32 bits, bit 31 selects predication on pr
  opcode encodings are fixed, the instruction memory image depends on them
*/
`include "harmonica_settings.svh"

package harmonica_pkg;

  // ========================================
  // instruction encoding
  // ========================================
  typedef enum logic [3:0] {
    OP_NOP    = 4'h0,
    OP_LANEID = 4'h1,  // rd = global thread number
    OP_ADDI   = 4'h2,
    OP_ADD    = 4'h3,
    OP_SUB    = 4'h4,
    OP_AND    = 4'h5,
    OP_XOR    = 4'h6,
    OP_SETNZ  = 4'h7,  // writes a predicate register
    OP_JMP    = 4'h8,
    OP_ST     = 4'h9
  } opcode_e;

  typedef logic [$clog2(`NUM_WARPS)-1:0] warp_id_t;
  typedef logic [$clog2(`NUM_REGS)-1:0]  reg_addr_t;
  typedef logic [`WORD_WIDTH-1:0]        lane_word_t;
  typedef lane_word_t [`NUM_LANES-1:0]   lane_vec_t;
  typedef logic [`NUM_LANES-1:0]         lane_mask_t;

  typedef struct packed {
    logic      pred_on;  // [31]
    reg_addr_t pr;       // [30:28]
    opcode_e   opcode;   // [27:24]
    reg_addr_t rd;       // [23:21]
    reg_addr_t rs1;      // [20:18]
    reg_addr_t rs2;      // [17:15]
    logic [14:0] imm;    // zero extended on use
  } instr_t;

  // ========================================
  // pipeline payloads
  // ========================================
  typedef struct packed {
    warp_id_t             warp_id;
    logic [`PC_WIDTH-1:0] pc;
  } warp_state_t;

  typedef struct packed {
    opcode_e     opcode;
    reg_addr_t   rd;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    reg_addr_t   pr;
    logic        pred_on;
    logic [14:0] imm;
    logic        gpr_write;
    logic        pred_write;
    logic        is_store;
    logic        is_jump;
  } ctrl_t;

  typedef struct packed {
    logic        valid;
    warp_state_t warp;
    ctrl_t       ctrl;
  } stage_t;

  typedef struct packed {
    logic       valid;
    warp_id_t   warp_id;
    reg_addr_t  rd;
    logic       is_pred;    // predicate file target, bit 0 per lane
    lane_mask_t lane_mask;
    lane_vec_t  data;
  } wb_t;

  typedef struct packed {
    logic [`PC_WIDTH-1:0] addr;
    lane_vec_t            data;
    lane_mask_t           mask;
  } store_req_t;

endpackage

// ==== warp_table.sv ====
/*
  FIFO of warp states, holds every warp in order at pc 0 after reset
  no overflow check, only NUM_WARPS warps ever exist
  an empty table hands a returning warp straight through
*/
`include "harmonica_settings.svh"

module warp_table import harmonica_pkg::*; (
  input  logic        phi,
  input  logic        reset,
  input  logic        push_valid,
  input  warp_state_t push_state,
  output logic        pop_valid,
  output warp_state_t pop_state
);

  localparam int PTR_W = $clog2(`NUM_WARPS);
  localparam int CNT_W = $clog2(`NUM_WARPS + 1);

  warp_state_t      slots [`NUM_WARPS];
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] wr_ptr;
  logic [CNT_W-1:0] count;  // occupancy
  logic             empty;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(`NUM_WARPS - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign empty     = (count == '0);
  assign pop_valid = !empty || push_valid;                  // pops whenever anything is there
  assign pop_state = empty ? push_state : slots[rd_ptr];   // bypass on empty

  always_ff @(posedge phi or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < `NUM_WARPS; i++) begin
        slots[i] <= '{warp_id: warp_id_t'(i), pc: '0};
      end
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= CNT_W'(`NUM_WARPS);  // full at start
    end else if (!empty) begin
      rd_ptr <= next_ptr(rd_ptr);
      if (push_valid) begin
        slots[wr_ptr] <= push_state;
        wr_ptr        <= next_ptr(wr_ptr);
      end else begin
        count <= count - 1'b1;  // pop without refill
      end
    end
  end

endmodule

// ==== fetch_decode.sv ====
/*
  fetch request register and decoder
  imem_data must be valid in the same cycle as imem_addr, no wait states
*/
`include "harmonica_settings.svh"

module fetch_decode import harmonica_pkg::*; (
  input  logic                 phi,
  input  logic                 reset,
  input  logic                 issue_valid,
  input  warp_state_t          issue_state,
  output logic [`PC_WIDTH-1:0] imem_addr,
  output logic                 imem_req_valid,
  input  instr_t               imem_data,
  output stage_t               fetch_out
);

  logic        req_valid_q;
  warp_state_t req_q;  // warp being fetched
  ctrl_t       ctrl;

  always_ff @(posedge phi or posedge reset) begin
    if (reset) begin
      req_valid_q <= 1'b0;
    end else begin
      req_valid_q <= issue_valid;
    end
  end

  always_ff @(posedge phi) begin
    if (issue_valid) req_q <= issue_state;
  end

  assign imem_addr      = req_q.pc;
  assign imem_req_valid = req_valid_q;

  // ========================================
  // decode
  // ========================================
  always_comb begin
    ctrl         = '0;
    ctrl.opcode  = imem_data.opcode;
    ctrl.rd      = imem_data.rd;
    ctrl.rs1     = imem_data.rs1;
    ctrl.rs2     = imem_data.rs2;
    ctrl.pr      = imem_data.pr;
    ctrl.pred_on = imem_data.pred_on;
    ctrl.imm     = imem_data.imm;
    case (imem_data.opcode)
      OP_LANEID, OP_ADDI, OP_ADD, OP_SUB, OP_AND, OP_XOR: ctrl.gpr_write = 1'b1;
      OP_SETNZ: ctrl.pred_write = 1'b1;
      OP_ST:    ctrl.is_store   = 1'b1;
      OP_JMP:   ctrl.is_jump    = 1'b1;
      default:  ;  // nop and unknown codes do nothing
    endcase
  end

  assign fetch_out = '{valid: req_valid_q, warp: req_q, ctrl: ctrl};

endmodule

// ==== register_block.sv ====
/*
  per warp, per register, per lane storage, cleared at reset
  reads are combinational, a write lands on the clock edge in enabled lanes only
*/
`include "harmonica_settings.svh"

module register_block import harmonica_pkg::*; #(
  parameter type entry_t  = logic,
  parameter int  NUM_READ = 1
) (
  input  logic                         phi,
  input  logic                         reset,
  input  warp_id_t                     read_warp,
  input  reg_addr_t                    read_addr [NUM_READ],
  output entry_t [`NUM_LANES-1:0]      read_data [NUM_READ],
  input  logic                         write_en,
  input  warp_id_t                     write_warp,
  input  reg_addr_t                    write_addr,
  input  lane_mask_t                   write_lane_en,
  input  entry_t [`NUM_LANES-1:0]      write_data
);

  entry_t [`NUM_LANES-1:0] regs [`NUM_WARPS][`NUM_REGS];

  always_comb begin
    for (int r = 0; r < NUM_READ; r++) begin
      read_data[r] = regs[read_warp][read_addr[r]];
    end
  end

  always_ff @(posedge phi or posedge reset) begin
    if (reset) begin
      for (int w = 0; w < `NUM_WARPS; w++) begin
        for (int a = 0; a < `NUM_REGS; a++) regs[w][a] <= '0;
      end
    end else if (write_en) begin
      for (int l = 0; l < `NUM_LANES; l++) begin
        if (write_lane_en[l]) regs[write_warp][write_addr][l] <= write_data[l];  // masked lane
      end
    end
  end

endmodule

// ==== pred_read_stage.sv ====
/*
  predicate register read and lane enable
  unpredicated instructions run on all lanes
*/
`include "harmonica_settings.svh"

module pred_read_stage import harmonica_pkg::*; (
  input  logic       phi,
  input  logic       reset,
  input  stage_t     stage_in,
  input  wb_t        wb,
  output stage_t     stage_out,
  output lane_mask_t lane_en
);

  stage_t                stage_q;       // warp sitting in this stage
  reg_addr_t             pred_addr [1];
  logic [`NUM_LANES-1:0] pred_bits [1];
  logic [`NUM_LANES-1:0] pred_wdata;
  lane_mask_t            lane_en_d;

  assign pred_addr[0] = stage_q.ctrl.pr;

  always_comb begin
    for (int l = 0; l < `NUM_LANES; l++) pred_wdata[l] = wb.data[l][0];  // bit 0 only
  end

  register_block #(.entry_t(logic), .NUM_READ(1)) pred_file_inst (
    .phi(phi), .reset(reset),
    .read_warp(stage_q.warp.warp_id), .read_addr(pred_addr), .read_data(pred_bits),
    .write_en(wb.valid && wb.is_pred), .write_warp(wb.warp_id), .write_addr(wb.rd),
    .write_lane_en(wb.lane_mask), .write_data(pred_wdata)
  );

  assign lane_en_d = stage_q.ctrl.pred_on ? pred_bits[0] : '1;

  always_ff @(posedge phi or posedge reset) begin
    if (reset) begin
      stage_q   <= '0;
      stage_out <= '0;
      lane_en   <= '0;
    end else begin
      stage_q   <= stage_in;
      stage_out <= stage_q;
      lane_en   <= lane_en_d;
    end
  end

endmodule

// ==== gpr_read_stage.sv ====
/*
  general register read, three ports for rs1, rs2 and rd
  rd is read for the store data
*/
`include "harmonica_settings.svh"

module gpr_read_stage import harmonica_pkg::*; (
  input  logic       phi,
  input  logic       reset,
  input  stage_t     stage_in,
  input  lane_mask_t lane_en_in,
  input  wb_t        wb,
  output stage_t     stage_out,
  output lane_mask_t lane_en_out,
  output lane_vec_t  rs1_vec,
  output lane_vec_t  rs2_vec,
  output lane_vec_t  rd_vec
);

  reg_addr_t rd_addr  [3];
  lane_vec_t gpr_data [3];

  assign rd_addr[0] = stage_in.ctrl.rs1;
  assign rd_addr[1] = stage_in.ctrl.rs2;
  assign rd_addr[2] = stage_in.ctrl.rd;  // store data source

  register_block #(.entry_t(lane_word_t), .NUM_READ(3)) gpr_file_inst (
    .phi(phi), .reset(reset),
    .read_warp(stage_in.warp.warp_id), .read_addr(rd_addr), .read_data(gpr_data),
    .write_en(wb.valid && !wb.is_pred), .write_warp(wb.warp_id), .write_addr(wb.rd),
    .write_lane_en(wb.lane_mask), .write_data(wb.data)
  );

  always_ff @(posedge phi or posedge reset) begin
    if (reset) begin
      stage_out   <= '0;
      lane_en_out <= '0;
    end else begin
      stage_out   <= stage_in;
      lane_en_out <= lane_en_in;
    end
  end

  // operands into execute
  always_ff @(posedge phi) begin
    rs1_vec <= gpr_data[0];
    rs2_vec <= gpr_data[1];
    rd_vec  <= gpr_data[2];
  end

endmodule

// ==== lane_alu.sv ====
/*
  one lane of arithmetic, purely combinational
  SETNZ leaves its flag in bit 0, upper bits zero
*/
module lane_alu import harmonica_pkg::*; (
  input  opcode_e    opcode,
  input  lane_word_t lane_index,  // global thread number
  input  lane_word_t a,
  input  lane_word_t b,
  input  lane_word_t imm,
  output lane_word_t result
);

  always_comb begin
    case (opcode)
      OP_LANEID: result = lane_index;
      OP_ADDI:   result = a + imm;
      OP_ADD:    result = a + b;
      OP_SUB:    result = a - b;
      OP_AND:    result = a & b;
      OP_XOR:    result = a ^ b;
      OP_SETNZ:  result = lane_word_t'(a != '0);  // predicate bit
      default:   result = '0;  // no register result
    endcase
  end

endmodule

// ==== exec_stage.sv ====
/*
  lane ALUs, store request, writeback and warp return
  stores are single cycle strobes, memory must take every one
  a JMP always redirects the whole warp
*/
`include "harmonica_settings.svh"

module exec_stage import harmonica_pkg::*; (
  input  logic        phi,
  input  logic        reset,
  input  stage_t      stage_in,
  input  lane_mask_t  lane_en,
  input  lane_vec_t   rs1_vec,
  input  lane_vec_t   rs2_vec,
  input  lane_vec_t   rd_vec,
  output logic        dmem_req_valid,
  output store_req_t  dmem_req,
  output wb_t         wb,
  output logic        ret_valid,
  output warp_state_t ret_state
);

  lane_word_t           imm_word;
  lane_word_t           lane_index [`NUM_LANES];
  lane_vec_t            alu_vec;
  logic [`PC_WIDTH-1:0] next_pc;

  assign imm_word = lane_word_t'(stage_in.ctrl.imm);  // zero extend

  for (genvar l = 0; l < `NUM_LANES; l++) begin : g_lane
    assign lane_index[l] = lane_word_t'(stage_in.warp.warp_id) * lane_word_t'(`NUM_LANES)
                         + lane_word_t'(l);
    lane_alu lane_alu_inst (
      .opcode(stage_in.ctrl.opcode), .lane_index(lane_index[l]),
      .a(rs1_vec[l]), .b(rs2_vec[l]), .imm(imm_word), .result(alu_vec[l])
    );
  end

  // store from the execute registers, address from lane 0
  assign dmem_req_valid = stage_in.valid && stage_in.ctrl.is_store;
  assign dmem_req.addr  = rs1_vec[0][`PC_WIDTH-1:0] + `PC_WIDTH'(stage_in.ctrl.imm);
  assign dmem_req.data  = rd_vec;
  assign dmem_req.mask  = lane_en;

  assign next_pc = stage_in.ctrl.is_jump ? `PC_WIDTH'(stage_in.ctrl.imm)
                                         : stage_in.warp.pc + 1'b1;

  always_ff @(posedge phi or posedge reset) begin
    if (reset) begin
      wb        <= '0;
      ret_valid <= 1'b0;
    end else begin
      wb.valid     <= stage_in.valid && (stage_in.ctrl.gpr_write || stage_in.ctrl.pred_write);
      wb.warp_id   <= stage_in.warp.warp_id;
      wb.rd        <= stage_in.ctrl.rd;
      wb.is_pred   <= stage_in.ctrl.pred_write;
      wb.lane_mask <= lane_en;  // disabled lanes keep old value
      wb.data      <= alu_vec;
      ret_valid    <= stage_in.valid;  // every instruction returns its warp
    end
  end

  always_ff @(posedge phi) begin
    ret_state <= '{warp_id: stage_in.warp.warp_id, pc: next_pc};
  end

endmodule

// ==== harmonica_core.sv ====
/*
  warp pipeline top, table then fetch, predicate read, gpr read, execute
  no back-pressure on any port
  instruction data is expected in the same cycle as its address
*/
`include "harmonica_settings.svh"

module harmonica_core import harmonica_pkg::*; (
  input  logic                 phi,
  input  logic                 reset,
  output logic [`PC_WIDTH-1:0] imem_addr,
  output logic                 imem_req_valid,
  input  instr_t               imem_data,
  output logic                 dmem_req_valid,
  output store_req_t           dmem_req
);

  // ========================================
  // inter-stage wires
  // ========================================
  logic        issue_valid;
  warp_state_t issue_state;
  stage_t      fetch_stage;
  stage_t      pred_stage;
  stage_t      exec_stage_in;
  lane_mask_t  pred_lane_en;   // into gpr read
  lane_mask_t  exec_lane_en;   // into execute
  lane_vec_t   rs1_vec;
  lane_vec_t   rs2_vec;
  lane_vec_t   rd_vec;
  wb_t         wb;
  logic        ret_valid;
  warp_state_t ret_state;

  warp_table warp_table_inst (
    .phi(phi), .reset(reset), .push_valid(ret_valid), .push_state(ret_state),
    .pop_valid(issue_valid), .pop_state(issue_state)
  );

  fetch_decode fetch_decode_inst (
    .phi(phi), .reset(reset), .issue_valid(issue_valid), .issue_state(issue_state),
    .imem_addr(imem_addr), .imem_req_valid(imem_req_valid), .imem_data(imem_data),
    .fetch_out(fetch_stage)
  );

  pred_read_stage pred_read_stage_inst (
    .phi(phi), .reset(reset), .stage_in(fetch_stage), .wb(wb),
    .stage_out(pred_stage), .lane_en(pred_lane_en)
  );

  gpr_read_stage gpr_read_stage_inst (
    .phi(phi), .reset(reset), .stage_in(pred_stage), .lane_en_in(pred_lane_en), .wb(wb),
    .stage_out(exec_stage_in), .lane_en_out(exec_lane_en),
    .rs1_vec(rs1_vec), .rs2_vec(rs2_vec), .rd_vec(rd_vec)
  );

  exec_stage exec_stage_inst (
    .phi(phi), .reset(reset), .stage_in(exec_stage_in), .lane_en(exec_lane_en),
    .rs1_vec(rs1_vec), .rs2_vec(rs2_vec), .rd_vec(rd_vec),
    .dmem_req_valid(dmem_req_valid), .dmem_req(dmem_req),
    .wb(wb), .ret_valid(ret_valid), .ret_state(ret_state)
  );

endmodule

// ==== harmonica_core_tb.sv ====
/*
  directed testbench for the warp pipeline
  warps issue round robin, so fetch k and each store step belong to warp k mod NUM_WARPS
  every program ends in a jump, no pc runs past the image
*/
`include "harmonica_settings.svh"

module harmonica_core_tb import harmonica_pkg::*; ();

  localparam int TOTAL_INSTR = 40;  // per warp, summed over all tests
  localparam int CYCLE_LIMIT = 20 * TOTAL_INSTR * `NUM_WARPS + 100;
  localparam int IMEM_DEPTH  = 64;

  logic                 phi;
  logic                 reset;
  logic [`PC_WIDTH-1:0] imem_addr;
  logic                 imem_req_valid;
  instr_t               imem_data;
  logic                 dmem_req_valid;
  store_req_t           dmem_req;

  instr_t               imem [IMEM_DEPTH];  // instruction memory image
  store_req_t           store_q [$];        // stores seen on dmem
  store_req_t           exp_q [$];
  logic [`PC_WIDTH-1:0] fetch_q [$];        // fetch addresses in issue order
  int                   cycles = 0;

  harmonica_core harmonica_core_inst (
    .phi(phi), .reset(reset), .imem_addr(imem_addr), .imem_req_valid(imem_req_valid),
    .imem_data(imem_data), .dmem_req_valid(dmem_req_valid), .dmem_req(dmem_req)
  );

  initial phi = 1'b0;
  always #5 phi = ~phi;

  // ========================================
  // memory models and timeout
  // ========================================
  always @(negedge phi) begin
    imem_data <= imem[imem_addr[$clog2(IMEM_DEPTH)-1:0]];  // same cycle answer
    if (imem_req_valid) fetch_q.push_back(imem_addr);
    if (dmem_req_valid) store_q.push_back(dmem_req);      // memory takes every store
  end

  always @(posedge phi) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: tests still running after %0d cycles", cycles);
      $display("FAIL: see errors above");
      $fatal(1, "run stopped by timeout");
    end
  end

  // ========================================
  // helpers and compare tasks
  // ========================================
  function automatic instr_t encode_instr(bit pred_on, int pr, opcode_e op, int rd,
                                          int rs1, int rs2, int imm);
    instr_t i;
    i.pred_on = pred_on;
    i.pr      = reg_addr_t'(pr);
    i.opcode  = op;
    i.rd      = reg_addr_t'(rd);
    i.rs1     = reg_addr_t'(rs1);
    i.rs2     = reg_addr_t'(rs2);
    i.imm     = 15'(imm);
    return i;
  endfunction

  function automatic store_req_t make_store(int addr, lane_vec_t data, lane_mask_t mask);
    store_req_t s;
    s.addr = `PC_WIDTH'(addr);
    s.data = data;
    s.mask = mask;
    return s;
  endfunction

  function automatic lane_word_t thread_id(int w, int j);
    return lane_word_t'(w * `NUM_LANES + j);  // global thread number
  endfunction

  task automatic clear_imem();
    for (int a = 0; a < IMEM_DEPTH; a++) begin
      imem[a] = encode_instr(1'b0, 0, OP_NOP, 0, 0, 0, a);  // nop tagged with its address
    end
    exp_q.delete();
  endtask

  task automatic stop_on_error();
    $display("FAIL: see errors above");
    $fatal(1, "stopped at first error");
  endtask

  task automatic compare_store(int idx, store_req_t exp, store_req_t got);
    if (got !== exp) begin
      $display("FAIL dmem_req[%0d]: expected %h, got %h", idx, exp, got);
      stop_on_error();
    end
  endtask

  task automatic compare_bit(string name, logic exp, logic got);
    if (got !== exp) begin
      $display("FAIL %s: expected %h, got %h", name, exp, got);
      stop_on_error();
    end
  endtask

  task automatic compare_pc(string name, logic [`PC_WIDTH-1:0] exp,
                            logic [`PC_WIDTH-1:0] got);
    if (got !== exp) begin
      $display("FAIL %s: expected %h, got %h", name, exp, got);
      stop_on_error();
    end
  endtask

  // reset for 4 cycles, request strobes stay low throughout
  task automatic apply_reset();
    @(negedge phi);
    reset = 1'b1;
    repeat (4) begin
      @(negedge phi);
      compare_bit("imem_req_valid", 1'b0, imem_req_valid);
      compare_bit("dmem_req_valid", 1'b0, dmem_req_valid);
    end
    store_q.delete();
    fetch_q.delete();
    reset = 1'b0;
    #1;  // first cycle out of reset
    compare_bit("imem_req_valid", 1'b0, imem_req_valid);
    compare_bit("dmem_req_valid", 1'b0, dmem_req_valid);
  endtask

  task automatic check_stores();
    while (store_q.size() < exp_q.size()) @(negedge phi);
    foreach (exp_q[i]) compare_store(i, exp_q[i], store_q[i]);
  endtask

  // ========================================
  // directed tests
  // ========================================
  task automatic test_reset();
    clear_imem();
    imem[0] = encode_instr(1'b0, 0, OP_JMP, 0, 0, 0, 0);  // spin at pc 0
    apply_reset();
    while (fetch_q.size() < `NUM_WARPS) @(negedge phi);
    for (int k = 0; k < `NUM_WARPS; k++) compare_pc("imem_addr", '0, fetch_q[k]);
  endtask

  task automatic test_laneid_store();
    lane_vec_t data;
    clear_imem();
    imem[0] = encode_instr(1'b0, 0, OP_LANEID, 1, 0, 0, 0);
    imem[1] = encode_instr(1'b0, 0, OP_ST, 1, 0, 0, 'h10);  // r0 base, addr = imm
    imem[2] = encode_instr(1'b0, 0, OP_JMP, 0, 0, 0, 2);
    for (int w = 0; w < `NUM_WARPS; w++) begin
      for (int j = 0; j < `NUM_LANES; j++) data[j] = thread_id(w, j);
      exp_q.push_back(make_store('h10, data, '1));
    end
    apply_reset();
    check_stores();
  endtask

  task automatic test_alu();
    lane_word_t r1;
    lane_word_t r2;
    lane_vec_t  res [5];
    int         st_rd [5] = '{1, 3, 4, 5, 6};
    clear_imem();
    imem[0] = encode_instr(1'b0, 0, OP_ADDI, 1, 0, 0, 'h4a5a);  // bit 14 set, no sign
    imem[1] = encode_instr(1'b0, 0, OP_LANEID, 2, 0, 0, 0);
    imem[2] = encode_instr(1'b0, 0, OP_ADD, 3, 1, 2, 0);
    imem[3] = encode_instr(1'b0, 0, OP_SUB, 4, 2, 1, 0);        // wraps negative
    imem[4] = encode_instr(1'b0, 0, OP_AND, 5, 3, 1, 0);
    imem[5] = encode_instr(1'b0, 0, OP_XOR, 6, 3, 2, 0);
    for (int s = 0; s < 5; s++) begin
      imem[6 + s] = encode_instr(1'b0, 0, OP_ST, st_rd[s], 0, 0, 'h20 + s);
    end
    imem[11] = encode_instr(1'b0, 0, OP_JMP, 0, 0, 0, 11);
    for (int s = 0; s < 5; s++) begin
      for (int w = 0; w < `NUM_WARPS; w++) begin
        for (int j = 0; j < `NUM_LANES; j++) begin
          r1        = 32'h0000_4a5a;
          r2        = thread_id(w, j);
          res[0][j] = r1;
          res[1][j] = r1 + r2;
          res[2][j] = r2 - r1;
          res[3][j] = res[1][j] & r1;
          res[4][j] = res[1][j] ^ r2;
        end
        exp_q.push_back(make_store('h20 + s, res[s], '1));
      end
    end
    apply_reset();
    check_stores();
  endtask

  // thread 2 gets a zero predicate, its r4 keeps the unpredicated value
  task automatic test_predication();
    lane_vec_t  data;
    lane_mask_t pred;
    clear_imem();
    imem[0] = encode_instr(1'b0, 0, OP_LANEID, 1, 0, 0, 0);
    imem[1] = encode_instr(1'b0, 0, OP_ADDI, 3, 0, 0, 2);
    imem[2] = encode_instr(1'b0, 0, OP_SUB, 2, 1, 3, 0);    // tid - 2
    imem[3] = encode_instr(1'b0, 0, OP_SETNZ, 1, 2, 0, 0);  // p1
    imem[4] = encode_instr(1'b0, 0, OP_ADDI, 4, 1, 0, 'h40);
    imem[5] = encode_instr(1'b1, 1, OP_ADDI, 4, 1, 0, 'h300);
    imem[6] = encode_instr(1'b1, 1, OP_ST, 4, 1, 0, 'h30);  // base r1, lane 0 tid
    imem[7] = encode_instr(1'b0, 0, OP_ST, 4, 0, 0, 'h31);
    imem[8] = encode_instr(1'b0, 0, OP_JMP, 0, 0, 0, 8);
    for (int s = 0; s < 2; s++) begin
      for (int w = 0; w < `NUM_WARPS; w++) begin
        for (int j = 0; j < `NUM_LANES; j++) begin
          pred[j] = (thread_id(w, j) - 32'd2) != 0;
          data[j] = pred[j] ? thread_id(w, j) + 32'h300 : thread_id(w, j) + 32'h40;
        end
        if (s == 0) exp_q.push_back(make_store('h30 + w * `NUM_LANES, data, pred));
        else exp_q.push_back(make_store('h31, data, '1));
      end
    end
    apply_reset();
    check_stores();
  endtask

  task automatic test_jump_loop();
    lane_vec_t data;
    clear_imem();
    imem[0] = encode_instr(1'b0, 0, OP_LANEID, 1, 0, 0, 0);
    imem[1] = encode_instr(1'b0, 0, OP_ADDI, 2, 1, 0, 'h11);
    imem[2] = encode_instr(1'b0, 0, OP_ST, 2, 0, 0, 'h50);
    imem[3] = encode_instr(1'b0, 0, OP_JMP, 0, 0, 0, 0);    // back to the top
    for (int it = 0; it < 3; it++) begin
      for (int w = 0; w < `NUM_WARPS; w++) begin
        for (int j = 0; j < `NUM_LANES; j++) data[j] = thread_id(w, j) + 32'h11;
        exp_q.push_back(make_store('h50, data, '1));
      end
    end
    apply_reset();
    check_stores();
    // two full passes, each warp walks pcs 0..3 in turn
    for (int k = 0; k < 8 * `NUM_WARPS; k++) begin
      compare_pc("imem_addr", `PC_WIDTH'((k / `NUM_WARPS) % 4), fetch_q[k]);
    end
  endtask

  initial begin
    reset     = 1'b1;
    imem_data = '0;
    clear_imem();
    test_reset();
    test_laneid_store();
    test_alu();
    test_predication();
    test_jump_loop();
    $display("PASS: all tests");
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+.
harmonica_pkg.sv
warp_table.sv
fetch_decode.sv
register_block.sv
pred_read_stage.sv
gpr_read_stage.sv
lane_alu.sv
exec_stage.sv
harmonica_core.sv
harmonica_core_tb.sv
